// File: Makefile
VERILATOR ?= verilator
TOP       ?= rsBench
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/rsBench.sv
`timescale 1ns/10ps
`default_nettype none

module rsBench;

    logic CLK = 1'b0;
    logic Reset, Issue, MemOp, RegW, ALUSrc, CdbValid, CdbFlagWrite;
    rsPkg::regIdxT Rd, RA1, RA2;
    rsPkg::wordT ExtImm, CdbValue;
    rsPkg::tagT CdbTag;
    logic [3:0] Cond, FlagW;
    logic [4:0] Op, Shamt5;
    logic [1:0] Sh;
    logic Full, AluExec, MemExec;
    logic [4:0] AluOp, AluShamt5, MemOp2;
    logic [3:0] AluCond, AluFlagW;
    logic [1:0] AluSh;
    rsPkg::tagT AluTag, MemTag;
    rsPkg::wordT AluSrcA, AluSrcB, MemSrcA, MemSrcB;

    // Reference model of the register status table and the tag pool.
    rsPkg::wordT regs [16];
    rsPkg::tagT  prod [16];
    logic [15:0] busy;
    rsPkg::tagT  modelTail;
    logic [31:0] lfsr = 32'hebae4adb;
    logic [4:0]  expOp, expShamt;
    logic [1:0]  expSh;
    rsPkg::wordT expImm;
    int errors = 0;
    int testErrors = 0;
    int tests = 0;
    int cycles = 0;
    rsPkg::tagT t0, t1, t2, t3;
    rsPkg::wordT v;

    reservationStations reservationStations_inst (.*);

    always #2 CLK = ~CLK;

    // Run limit is six tests of 200 cycles each.
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= 1200) begin
            $display("Timeout, run went past %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic issueOp(input logic mem, input rsPkg::regIdxT rd, input rsPkg::regIdxT ra1,
                           input logic [3:0] cond, input logic [3:0] flagW,
                           output rsPkg::tagT tag);
        logic taken;
        logic [31:0] r;
        taken = 1'b0;
        r = randBits(12);
        expOp = r[4:0];
        expShamt = r[9:5];
        expSh = r[11:10];
        expImm = randBits(32);
        @(posedge CLK);
        Issue <= 1'b1;
        MemOp <= mem;
        RegW <= 1'b1;
        Rd <= rd;
        RA1 <= ra1;
        RA2 <= '0;
        ALUSrc <= 1'b1;
        ExtImm <= expImm;
        Cond <= cond;
        FlagW <= flagW;
        Op <= expOp;
        Shamt5 <= expShamt;
        Sh <= expSh;
        while (!taken) begin
            @(negedge CLK);
            taken = !Full;
            @(posedge CLK);
        end
        Issue <= 1'b0;
        tag = modelTail;
        modelTail = modelTail + rsPkg::tagT'(1);
        busy[rd] = 1'b1;
        prod[rd] = tag;
    endtask

    // Expects the dispatch two edges after the last issue or broadcast.
    task automatic dispatch(input logic mem, input rsPkg::tagT tag, input rsPkg::wordT a,
                            input rsPkg::wordT b);
        int n;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!(mem ? MemExec : AluExec) && n < 50);
        if (n >= 50) begin
            $display("No dispatch of tag %0d within 50 cycles", tag);
            errors++;
        end
        checkValue("dispatch latency", 32'(n), 32'd2);
        checkValue(mem ? "AluExec" : "MemExec", 32'(mem ? AluExec : MemExec), 32'd0);
        checkValue(mem ? "MemTag" : "AluTag", 32'(mem ? MemTag : AluTag), 32'(tag));
        checkValue(mem ? "MemSrcA" : "AluSrcA", mem ? MemSrcA : AluSrcA, a);
        checkValue(mem ? "MemSrcB" : "AluSrcB", mem ? MemSrcB : AluSrcB, b);
    endtask

    task automatic quiet(int n);
        repeat (n) begin
            @(negedge CLK);
            if (AluExec || MemExec) begin
                $display("Dispatch while an operand or flag was still missing");
                errors++;
            end
        end
    endtask

    task automatic broadcast(input rsPkg::tagT tag, input rsPkg::wordT value, input logic fw);
        @(posedge CLK);
        CdbValid <= 1'b1;
        CdbTag <= tag;
        CdbValue <= value;
        CdbFlagWrite <= fw;
        @(posedge CLK);
        CdbValid <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            if (busy[i] && prod[i] == tag) begin
                regs[i] = value;
                busy[i] = 1'b0;
            end
        end
    endtask

    task automatic endTest(string name);
        tests++;
        $display("%s: %0d errors", name, errors - testErrors);
        testErrors = errors;
    endtask

    initial begin
        Reset = 1'b1;
        {Issue, MemOp, RegW, ALUSrc, CdbValid, CdbFlagWrite} = '0;
        {Rd, RA1, RA2, CdbTag, Cond, FlagW, Op, Shamt5, Sh} = '0;
        ExtImm = '0;
        CdbValue = '0;
        busy = '0;
        modelTail = '0;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
            prod[i] = '0;
        end
        repeat (8) @(posedge CLK);
        Reset <= 1'b0;

        for (int k = 1; k <= 3; k++) begin
            issueOp(1'b0, rsPkg::regIdxT'(k), 4'd0, rsPkg::condAlways, 4'h0, t0);
            dispatch(1'b0, t0, '0, expImm);
            checkValue("AluTag", 32'(AluTag), 32'(k - 1));
            checkValue("AluOp", 32'(AluOp), 32'(expOp));
            checkValue("AluCond", 32'(AluCond), 32'(rsPkg::condAlways));
            checkValue("AluShamt5", 32'(AluShamt5), 32'(expShamt));
            checkValue("AluSh", 32'(AluSh), 32'(expSh));
            broadcast(t0, randBits(32), 1'b0);
        end
        endTest("ready ALU issue");

        issueOp(1'b0, 4'd2, 4'd0, rsPkg::condAlways, 4'h0, t0);
        dispatch(1'b0, t0, '0, expImm);
        issueOp(1'b0, 4'd3, 4'd2, rsPkg::condAlways, 4'h0, t1);
        quiet(4);
        v = randBits(32);
        broadcast(t0, v, 1'b0);
        dispatch(1'b0, t1, v, expImm);
        broadcast(t1, randBits(32), 1'b0);
        endTest("operand wait");

        issueOp(1'b0, 4'd4, 4'd0, rsPkg::condAlways, 4'hF, t0);
        dispatch(1'b0, t0, '0, expImm);
        checkValue("AluFlagW", 32'(AluFlagW), 32'hF);
        issueOp(1'b0, 4'd5, 4'd1, 4'h0, 4'h0, t1);
        v = expImm;
        quiet(3);
        issueOp(1'b0, 4'd6, 4'd1, rsPkg::condAlways, 4'h0, t2);
        dispatch(1'b0, t2, regs[1], expImm);
        broadcast(t0, randBits(32), 1'b1);
        dispatch(1'b0, t1, regs[1], v);
        broadcast(t1, randBits(32), 1'b0);
        broadcast(t2, randBits(32), 1'b0);
        endTest("flag wait");

        issueOp(1'b1, 4'd7, 4'd1, rsPkg::condAlways, 4'h0, t0);
        dispatch(1'b1, t0, regs[1], expImm);
        checkValue("MemOp2", 32'(MemOp2), 32'(expOp));
        broadcast(t0, randBits(32), 1'b0);
        endTest("memory routing");

        issueOp(1'b1, 4'd9, 4'd3, rsPkg::condAlways, 4'h0, t0);
        dispatch(1'b1, t0, regs[3], expImm);
        issueOp(1'b1, 4'd10, 4'd2, rsPkg::condAlways, 4'h0, t1);
        dispatch(1'b1, t1, regs[2], expImm);
        @(posedge CLK);
        Issue <= 1'b1;
        MemOp <= 1'b1;
        repeat (3) begin
            @(negedge CLK);
            checkValue("Full", 32'(Full), 32'd1);
        end
        @(posedge CLK);
        Issue <= 1'b0;
        broadcast(t0, randBits(32), 1'b0);
        @(negedge CLK);
        checkValue("Full", 32'(Full), 32'd0);
        issueOp(1'b1, 4'd11, 4'd9, rsPkg::condAlways, 4'h0, t2);
        dispatch(1'b1, t2, regs[9], expImm);
        broadcast(t2, randBits(32), 1'b0);
        // Wrap the pool onto the tag still held by the memory station.
        while (modelTail != t1) begin
            issueOp(1'b0, 4'd13, 4'd0, rsPkg::condAlways, 4'h0, t3);
            dispatch(1'b0, t3, '0, expImm);
            broadcast(t3, randBits(32), 1'b0);
        end
        @(posedge CLK);
        Issue <= 1'b1;
        MemOp <= 1'b0;
        @(negedge CLK);
        checkValue("Full", 32'(Full), 32'd1);
        @(posedge CLK);
        Issue <= 1'b0;
        broadcast(t1, randBits(32), 1'b0);
        @(negedge CLK);
        checkValue("Full", 32'(Full), 32'd0);
        endTest("back-pressure");

        issueOp(1'b0, 4'd8, 4'd0, rsPkg::condAlways, 4'h0, t0);
        dispatch(1'b0, t0, '0, expImm);
        issueOp(1'b0, 4'd8, 4'd0, rsPkg::condAlways, 4'h0, t1);
        dispatch(1'b0, t1, '0, expImm);
        v = randBits(32);
        broadcast(t1, v, 1'b0);
        broadcast(t0, randBits(32), 1'b0);
        issueOp(1'b0, 4'd12, 4'd8, rsPkg::condAlways, 4'h0, t3);
        dispatch(1'b0, t3, v, expImm);
        broadcast(t3, randBits(32), 1'b0);
        endTest("stale producer");

        errors += reservationStations_inst.assertChecks.failCount;
        $display("Tests run %0d, failed checks %0d", tests, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/rsBench_assert.sv
`timescale 1ns/10ps
`default_nettype none

module rsBench_assert (
    input logic                    CLK,
    input logic                    Reset,
    input logic                    Issue,
    input logic                    Full,
    input logic                    MemOp,
    input logic                    ALUSrc,
    input rsPkg::regIdxT           RA1,
    input logic [rsPkg::condW-1:0] Cond,
    input logic                    AluExec,
    input rsPkg::tagT              AluTag,
    input logic                    MemExec,
    input rsPkg::tagT              MemTag,
    input rsPkg::tagT              Tail
);

    int failCount = 0;

    // A second cycle of Exec must carry another entry.
    aluPulse: assert property (@(posedge CLK) disable iff (Reset)
        AluExec |=> !AluExec || (AluTag != $past(AluTag)))
        else begin $error("AluExec held for one entry"); failCount++; end

    memPulse: assert property (@(posedge CLK) disable iff (Reset)
        MemExec |=> !MemExec || (MemTag != $past(MemTag)))
        else begin $error("MemExec held for one entry"); failCount++; end

    resetState: assert property (@(posedge CLK)
        $fell(Reset) |-> !Full && !AluExec && !MemExec)
        else begin $error("Outputs not idle after reset"); failCount++; end

    // r0 is never written, so this issue has all operands.
    readyDispatch: assert property (@(posedge CLK) disable iff (Reset)
        Issue && !Full && !MemOp && ALUSrc && (RA1 == '0) && (Cond == rsPkg::condAlways)
        |=> ##1 AluExec)
        else begin $error("Ready issue missed two-edge dispatch"); failCount++; end

    noAcceptWhenFull: assert property (@(posedge CLK) disable iff (Reset)
        Issue && Full |=> $stable(Tail))
        else begin $error("Issue accepted while Full"); failCount++; end

endmodule

bind reservationStations rsBench_assert assertChecks (
    .CLK(CLK), .Reset(Reset), .Issue(Issue), .Full(Full), .MemOp(MemOp), .ALUSrc(ALUSrc),
    .RA1(RA1), .Cond(Cond), .AluExec(AluExec), .AluTag(AluTag), .MemExec(MemExec),
    .MemTag(MemTag), .Tail(tail)
);

`default_nettype wire

// File: design/cdbBus.sv
`timescale 1ns/10ps
`default_nettype none

interface cdbBus;

    logic       Valid;
    rsPkg::tagT Tag;
    rsPkg::wordT Value;
    logic       FlagWrite;

    // Stations, register status and tag pool listen.
    modport snoop (
        input Valid, Tag, Value, FlagWrite
    );

    // Broadcast side.
    modport drive (
        output Valid, Tag, Value, FlagWrite
    );

endinterface

`default_nettype wire

// File: design/registerStatus.sv
`timescale 1ns/10ps
`default_nettype none

module registerStatus (
    input  logic                    CLK,
    input  logic                    Reset,
    input  logic                    Accept,
    input  logic                    RegW,
    input  rsPkg::regIdxT           Rd,
    input  logic [rsPkg::nzcvW-1:0] FlagW,
    input  rsPkg::tagT              Tail,
    input  rsPkg::regIdxT           RA1,
    input  rsPkg::regIdxT           RA2,
    cdbBus.snoop                    Cdb,
    output logic                    Src1Busy,
    output logic                    Src2Busy,
    output rsPkg::tagT              Src1Tag,
    output rsPkg::tagT              Src2Tag,
    output rsPkg::wordT             Src1Value,
    output rsPkg::wordT             Src2Value,
    output logic                    FlagBusy,
    output rsPkg::tagT              FlagTag
);

    rsPkg::wordT               regValue [rsPkg::numRegs];
    rsPkg::tagT                prodTag  [rsPkg::numRegs];
    logic [rsPkg::numRegs-1:0] regBusy;
    logic                      flagPending;
    rsPkg::tagT                flagProd;
    logic                      hit1;
    logic                      hit2;
    logic                      flagHit;

    // Broadcast matches the latest producer.
    assign hit1    = Cdb.Valid && regBusy[RA1] && (prodTag[RA1] == Cdb.Tag);
    assign hit2    = Cdb.Valid && regBusy[RA2] && (prodTag[RA2] == Cdb.Tag);
    assign flagHit = Cdb.Valid && Cdb.FlagWrite && flagPending && (flagProd == Cdb.Tag);

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            regBusy     <= '0;
            flagPending <= 1'b0;
            flagProd    <= '0;
            for (int i = 0; i < rsPkg::numRegs; i++) begin
                regValue[i] <= '0;
                prodTag[i]  <= '0;
            end
        end else begin
            // Older producers no longer own the register.
            for (int i = 0; i < rsPkg::numRegs; i++) begin
                if (Cdb.Valid && regBusy[i] && (prodTag[i] == Cdb.Tag)) begin
                    regValue[i] <= Cdb.Value;
                    regBusy[i]  <= 1'b0;
                end
            end
            if (Accept && RegW) begin
                regBusy[Rd] <= 1'b1;
                prodTag[Rd] <= Tail;
            end
            if (flagHit) begin
                flagPending <= 1'b0;
            end
            if (Accept && (|FlagW)) begin
                flagPending <= 1'b1;
                flagProd    <= Tail;
            end
        end
    end

    // Same-cycle bypass from the CDB.
    assign Src1Busy  = regBusy[RA1] && !hit1;
    assign Src2Busy  = regBusy[RA2] && !hit2;
    assign Src1Tag   = prodTag[RA1];
    assign Src2Tag   = prodTag[RA2];
    assign Src1Value = hit1 ? Cdb.Value : regValue[RA1];
    assign Src2Value = hit2 ? Cdb.Value : regValue[RA2];
    assign FlagBusy  = flagPending && !flagHit;
    assign FlagTag   = flagProd;

endmodule

`default_nettype wire

// File: design/reservationStation.sv
`timescale 1ns/10ps
`default_nettype none

module reservationStation #(
    parameter int Depth = 2
) (
    input  logic                     CLK,
    input  logic                     Reset,
    input  logic                     Append,
    cdbBus.snoop                     Cdb,
    input  logic                     Src1Busy,
    input  rsPkg::tagT               Src1Tag,
    input  rsPkg::wordT              Src1Value,
    input  logic                     Src2Busy,
    input  rsPkg::tagT               Src2Tag,
    input  rsPkg::wordT              Src2Value,
    input  logic                     FlagBusy,
    input  rsPkg::tagT               FlagTag,
    input  logic                     ALUSrc,
    input  rsPkg::wordT              ExtImm,
    input  logic [rsPkg::condW-1:0]  Cond,
    input  logic [rsPkg::nzcvW-1:0]  FlagW,
    input  logic [rsPkg::opW-1:0]    Op,
    input  logic [rsPkg::shamtW-1:0] Shamt5,
    input  logic [rsPkg::shW-1:0]    Sh,
    input  rsPkg::tagT               Tail,
    output logic                     StationFull,
    output logic                     Exec,
    output logic [rsPkg::opW-1:0]    ExecOp,
    output logic [rsPkg::condW-1:0]  ExecCond,
    output logic [rsPkg::nzcvW-1:0]  ExecFlagW,
    output rsPkg::tagT               ExecTag,
    output logic [rsPkg::shamtW-1:0] ExecShamt5,
    output logic [rsPkg::shW-1:0]    ExecSh,
    output rsPkg::wordT              ExecSrcA,
    output rsPkg::wordT              ExecSrcB
);

    localparam int IdxW = (Depth > 1) ? $clog2(Depth) : 1;

    // Entry fields.
    logic [Depth-1:0]         busy, sent, waitA, waitB, waitF;
    logic [rsPkg::opW-1:0]    entOp    [Depth];
    logic [rsPkg::condW-1:0]  entCond  [Depth];
    logic [rsPkg::nzcvW-1:0]  entFlagW [Depth];
    logic [rsPkg::shamtW-1:0] entShamt [Depth];
    logic [rsPkg::shW-1:0]    entSh    [Depth];
    rsPkg::tagT               entDest  [Depth];
    rsPkg::tagT               tagA     [Depth];
    rsPkg::tagT               tagB     [Depth];
    rsPkg::tagT               tagF     [Depth];
    rsPkg::wordT              valA     [Depth];
    rsPkg::wordT              valB     [Depth];

    logic [Depth-1:0] hitA, hitB, hitF, done, ready, appendSel, pickSel;
    logic [IdxW-1:0]  pickIdx;

    always_comb begin
        for (int i = 0; i < Depth; i++) begin
            hitA[i]  = busy[i] && waitA[i] && Cdb.Valid && (tagA[i] == Cdb.Tag);
            hitB[i]  = busy[i] && waitB[i] && Cdb.Valid && (tagB[i] == Cdb.Tag);
            hitF[i]  = busy[i] && waitF[i] && Cdb.Valid && Cdb.FlagWrite
                       && (tagF[i] == Cdb.Tag);
            done[i]  = busy[i] && Cdb.Valid && (entDest[i] == Cdb.Tag);
            ready[i] = busy[i] && !sent[i] && !waitA[i] && !waitB[i] && !waitF[i];
        end
    end

    // Lowest free entry and lowest ready entry.
    assign appendSel = Append ? (~busy & (busy + Depth'(1))) : '0;
    assign pickSel   = ready & (~ready + Depth'(1));

    always_comb begin
        pickIdx = '0;
        for (int i = 0; i < Depth; i++) begin
            if (pickSel[i]) begin
                pickIdx = IdxW'(i);
            end
        end
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            busy  <= '0;
            sent  <= '0;
            waitA <= '0;
            waitB <= '0;
            waitF <= '0;
            Exec  <= 1'b0;
        end else begin
            for (int i = 0; i < Depth; i++) begin
                if (appendSel[i]) begin
                    busy[i]  <= 1'b1;
                    sent[i]  <= 1'b0;
                    waitA[i] <= Src1Busy;
                    waitB[i] <= !ALUSrc && Src2Busy;
                    waitF[i] <= (Cond != rsPkg::condAlways) && FlagBusy;
                end else begin
                    if (hitA[i]) waitA[i] <= 1'b0;
                    if (hitB[i]) waitB[i] <= 1'b0;
                    if (hitF[i]) waitF[i] <= 1'b0;
                    if (pickSel[i]) sent[i] <= 1'b1;
                    // Own result on the bus retires the entry.
                    if (done[i]) busy[i] <= 1'b0;
                end
            end
            Exec <= |ready;
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < Depth; i++) begin
            if (appendSel[i]) begin
                entOp[i]    <= Op;
                entCond[i]  <= Cond;
                entFlagW[i] <= FlagW;
                entShamt[i] <= Shamt5;
                entSh[i]    <= Sh;
                entDest[i]  <= Tail;
                tagA[i]     <= Src1Tag;
                tagB[i]     <= Src2Tag;
                tagF[i]     <= FlagTag;
                valA[i]     <= Src1Value;
                valB[i]     <= ALUSrc ? ExtImm : Src2Value;
            end else begin
                if (hitA[i]) valA[i] <= Cdb.Value;
                if (hitB[i]) valB[i] <= Cdb.Value;
            end
        end
        if (|ready) begin
            ExecOp     <= entOp[pickIdx];
            ExecCond   <= entCond[pickIdx];
            ExecFlagW  <= entFlagW[pickIdx];
            ExecTag    <= entDest[pickIdx];
            ExecShamt5 <= entShamt[pickIdx];
            ExecSh     <= entSh[pickIdx];
            ExecSrcA   <= valA[pickIdx];
            ExecSrcB   <= valB[pickIdx];
        end
    end

    assign StationFull = &busy;

endmodule

`default_nettype wire

// File: design/reservationStations.sv
`timescale 1ns/10ps
`default_nettype none

module reservationStations #(
    parameter int AluDepth = 4,
    parameter int MemDepth = 2
) (
    input  logic                     CLK,
    input  logic                     Reset,
    input  logic                     Issue,
    input  logic                     MemOp,
    input  logic                     RegW,
    input  rsPkg::regIdxT            Rd,
    input  rsPkg::regIdxT            RA1,
    input  rsPkg::regIdxT            RA2,
    input  logic                     ALUSrc,
    input  rsPkg::wordT              ExtImm,
    input  logic [rsPkg::condW-1:0]  Cond,
    input  logic [rsPkg::nzcvW-1:0]  FlagW,
    input  logic [rsPkg::opW-1:0]    Op,
    input  logic [rsPkg::shamtW-1:0] Shamt5,
    input  logic [rsPkg::shW-1:0]    Sh,
    input  logic                     CdbValid,
    input  rsPkg::tagT               CdbTag,
    input  rsPkg::wordT              CdbValue,
    input  logic                     CdbFlagWrite,
    output logic                     Full,
    output logic                     AluExec,
    output logic [rsPkg::opW-1:0]    AluOp,
    output logic [rsPkg::condW-1:0]  AluCond,
    output logic [rsPkg::nzcvW-1:0]  AluFlagW,
    output rsPkg::tagT               AluTag,
    output logic [rsPkg::shamtW-1:0] AluShamt5,
    output logic [rsPkg::shW-1:0]    AluSh,
    output rsPkg::wordT              AluSrcA,
    output rsPkg::wordT              AluSrcB,
    output logic                     MemExec,
    output logic [rsPkg::opW-1:0]    MemOp2,
    output rsPkg::tagT               MemTag,
    output rsPkg::wordT              MemSrcA,
    output rsPkg::wordT              MemSrcB
);

    cdbBus cdb ();

    logic        accept, tagFull, aluFull, memFull;
    rsPkg::tagT  tail, src1Tag, src2Tag, flagTag;
    logic        src1Busy, src2Busy, flagBusy;
    rsPkg::wordT src1Value, src2Value;

    assign cdb.Valid     = CdbValid;
    assign cdb.Tag       = CdbTag;
    assign cdb.Value     = CdbValue;
    assign cdb.FlagWrite = CdbFlagWrite;

    // Stall on no tag or no room in the target station.
    assign Full   = tagFull || (MemOp ? memFull : aluFull);
    assign accept = Issue && !Full;

    tagAllocator tagAllocator_inst (
        .CLK, .Reset, .Accept(accept), .Cdb(cdb), .Tail(tail), .TagFull(tagFull)
    );

    registerStatus registerStatus_inst (
        .CLK, .Reset, .Accept(accept), .RegW, .Rd, .FlagW, .Tail(tail), .RA1, .RA2,
        .Cdb(cdb), .Src1Busy(src1Busy), .Src2Busy(src2Busy), .Src1Tag(src1Tag),
        .Src2Tag(src2Tag), .Src1Value(src1Value), .Src2Value(src2Value),
        .FlagBusy(flagBusy), .FlagTag(flagTag)
    );

    reservationStation #(.Depth(AluDepth)) aluStation_inst (
        .CLK, .Reset, .Append(accept && !MemOp), .Cdb(cdb),
        .Src1Busy(src1Busy), .Src1Tag(src1Tag), .Src1Value(src1Value),
        .Src2Busy(src2Busy), .Src2Tag(src2Tag), .Src2Value(src2Value),
        .FlagBusy(flagBusy), .FlagTag(flagTag), .ALUSrc, .ExtImm, .Cond, .FlagW,
        .Op, .Shamt5, .Sh, .Tail(tail), .StationFull(aluFull), .Exec(AluExec),
        .ExecOp(AluOp), .ExecCond(AluCond), .ExecFlagW(AluFlagW), .ExecTag(AluTag),
        .ExecShamt5(AluShamt5), .ExecSh(AluSh), .ExecSrcA(AluSrcA), .ExecSrcB(AluSrcB)
    );

    // Offset rides in ExtImm for loads and stores.
    reservationStation #(.Depth(MemDepth)) memStation_inst (
        .CLK, .Reset, .Append(accept && MemOp), .Cdb(cdb),
        .Src1Busy(src1Busy), .Src1Tag(src1Tag), .Src1Value(src1Value),
        .Src2Busy(src2Busy), .Src2Tag(src2Tag), .Src2Value(src2Value),
        .FlagBusy(flagBusy), .FlagTag(flagTag), .ALUSrc, .ExtImm, .Cond, .FlagW,
        .Op, .Shamt5, .Sh, .Tail(tail), .StationFull(memFull), .Exec(MemExec),
        .ExecOp(MemOp2), .ExecCond(), .ExecFlagW(), .ExecTag(MemTag),
        .ExecShamt5(), .ExecSh(), .ExecSrcA(MemSrcA), .ExecSrcB(MemSrcB)
    );

endmodule

`default_nettype wire

// File: design/rsPkg.sv
`default_nettype none

package rsPkg;

    // Field widths.
    localparam int tagW    = 3;
    localparam int regIdxW = 4;
    localparam int wordW   = 32;
    localparam int opW     = 5;
    localparam int condW   = 4;
    localparam int shamtW  = 5;
    localparam int shW     = 2;
    localparam int nzcvW   = 4;

    // Tag pool and register file sizes.
    localparam int numTags = 1 << tagW;
    localparam int numRegs = 1 << regIdxW;

    // Result tag, which is also the tail slot in the pool.
    typedef logic [tagW-1:0] tagT;

    // Architectural register number.
    typedef logic [regIdxW-1:0] regIdxT;

    // Datapath word.
    typedef logic [wordW-1:0] wordT;

    // Condition that needs no flags.
    localparam logic [condW-1:0] condAlways = 4'hE;

endpackage

`default_nettype wire

// File: design/tagAllocator.sv
`timescale 1ns/10ps
`default_nettype none

module tagAllocator (
    input  logic        CLK,
    input  logic        Reset,
    input  logic        Accept,
    cdbBus.snoop        Cdb,
    output rsPkg::tagT  Tail,
    output logic        TagFull
);

    logic [rsPkg::numTags-1:0] tagBusy;

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            Tail    <= '0;
            tagBusy <= '0;
        end else begin
            // Broadcast returns its tag to the pool.
            if (Cdb.Valid) begin
                tagBusy[Cdb.Tag] <= 1'b0;
            end
            if (Accept) begin
                tagBusy[Tail] <= 1'b1;
                Tail          <= Tail + rsPkg::tagT'(1);
            end
        end
    end

    // Wait at the tail until that exact tag comes back.
    assign TagFull = tagBusy[Tail];

endmodule

`default_nettype wire

// File: src.f
design/rsPkg.sv
design/cdbBus.sv
design/tagAllocator.sv
design/registerStatus.sv
design/reservationStation.sv
design/reservationStations.sv
bench/rsBench_assert.sv
bench/rsBench.sv
